// File: compile.f
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
instr_decoder.sv
alu.sv
reg_file.sv
processor_core.sv
core_monitor.sv
tb_processor_core.sv

// File: tb_processor_core.sv
/* testbench for the multicycle RV32I core: serves a fixed program trace as
   instruction memory, coreMonitor compares fetch addresses and written data */
module tbProcessorCore;
  timeunit 1ns;
  timeprecision 100ps;

  // one executed instruction: word, its fetch address, debug value after it
  typedef struct packed {
    rvIsaPkg::wordT instr;
    rvIsaPkg::wordT fetchAddr;
    rvIsaPkg::wordT lastWrite;
  } traceStepT;

  localparam int numSteps = 32;
  localparam int fetchTimeout = 20; // cycles per wait
  localparam rvIsaPkg::wordT nopWord = 32'h0000_0013; // addi x0, x0, 0

  // execution order, x1 = -5 and x2 = 3 feed the alu ops and branches
  localparam traceStepT trace [numSteps] = '{
    '{32'hFFB0_0093, 32'h0000_0000, 32'hFFFF_FFFB}, // addi x1, x0, -5
    '{32'h0030_0113, 32'h0000_0004, 32'h0000_0003}, // addi x2, x0, 3
    '{32'h0020_81B3, 32'h0000_0008, 32'hFFFF_FFFE}, // add x3, x1, x2
    '{32'h4011_0233, 32'h0000_000C, 32'h0000_0008}, // sub x4, x2, x1
    '{32'h0020_A2B3, 32'h0000_0010, 32'h0000_0001}, // slt, -5 < 3
    '{32'h0020_B333, 32'h0000_0014, 32'h0000_0000}, // sltu, big unsigned
    '{32'h0020_C3B3, 32'h0000_0018, 32'hFFFF_FFF8}, // xor
    '{32'h0020_E433, 32'h0000_001C, 32'hFFFF_FFFB}, // or
    '{32'h0020_F4B3, 32'h0000_0020, 32'h0000_0003}, // and
    '{32'h0040_D513, 32'h0000_0024, 32'h0FFF_FFFF}, // srli x10, x1, 4
    '{32'h0045_1593, 32'h0000_0028, 32'hFFFF_FFF0}, // slli x11, x10, 4
    '{32'h4025_D613, 32'h0000_002C, 32'hFFFF_FFFC}, // srai x12, x11, 2
    '{32'h1234_5737, 32'h0000_0030, 32'h1234_5000}, // lui x14
    '{32'h0000_1797, 32'h0000_0034, 32'h0000_1034}, // auipc x15, 1
    '{32'h0020_8463, 32'h0000_0038, 32'h0000_1034}, // beq, not taken
    '{32'h0020_9463, 32'h0000_003C, 32'h0000_1034}, // bne +8, taken
    '{32'h0020_C463, 32'h0000_0044, 32'h0000_1034}, // blt +8, taken
    '{32'h0020_D463, 32'h0000_004C, 32'h0000_1034}, // bge, not taken
    '{32'h0020_E463, 32'h0000_0050, 32'h0000_1034}, // bltu, not taken
    '{32'h0020_F463, 32'h0000_0054, 32'h0000_1034}, // bgeu +8, taken
    '{32'h0020_0813, 32'h0000_005C, 32'h0000_0002}, // addi x16, x0, 2
    '{32'hFFF8_0813, 32'h0000_0060, 32'h0000_0001}, // countdown
    '{32'hFE08_1EE3, 32'h0000_0064, 32'h0000_0001}, // bne x16, x0, -4
    '{32'hFFF8_0813, 32'h0000_0060, 32'h0000_0000},
    '{32'hFE08_1EE3, 32'h0000_0064, 32'h0000_0000}, // loop exit
    '{32'h0080_08EF, 32'h0000_0068, 32'h0000_006C}, // jal x17, +8
    '{32'h0118_8967, 32'h0000_0070, 32'h0000_0074}, // jalr x18, 17(x17), odd sum
    '{32'h0070_8013, 32'h0000_007C, 32'h0000_0074}, // addi x0, x1, 7
    '{32'h0000_8A33, 32'h0000_0080, 32'hFFFF_FFFB}, // add x20, x1, x0
    '{32'h0011_2223, 32'h0000_0084, 32'hFFFF_FFFB}, // sw x1, 4(x2), no write-back
    '{32'h0001_2A83, 32'h0000_0088, 32'hFFFF_FFFB}, // lw, no write-back
    '{32'hC000_2B73, 32'h0000_008C, 32'hFFFF_FFFB}  // csrrs x22, cycle, x0 as nop
  };

  logic           clk;
  logic           resetn;
  rvIsaPkg::wordT memDout;
  rvIsaPkg::wordT memAddr;
  logic           memEn;
  rvIsaPkg::wordT lastWriteData;
  logic           addrCheckEn;
  logic           dataCheckEn;
  rvIsaPkg::wordT expAddr;
  rvIsaPkg::wordT expData;
  int             addrErrors;
  int             dataErrors;
  int             periodErrors;
  int             timeouts;

  processorCore dut_i (
    .clk(clk), .resetn(resetn), .memDout(memDout),
    .memAddr(memAddr), .memEn(memEn), .lastWriteData(lastWriteData)
  );

  coreMonitor traceCheck (
    .clk(clk), .memEn(memEn), .memAddr(memAddr), .lastWriteData(lastWriteData),
    .addrCheckEn(addrCheckEn), .expAddr(expAddr), .dataCheckEn(dataCheckEn),
    .expData(expData), .addrErrors(addrErrors), .dataErrors(dataErrors),
    .periodErrors(periodErrors)
  );

  always #2 clk = ~clk; // 4 ns period

  // steps cycle by cycle until memEn, sampled 1 ns after the edge
  task automatic waitFetch(output bit seen);
    int cycles;
    cycles = 0;
    while (!memEn && cycles < fetchTimeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    seen = memEn;
  endtask

  initial begin
    bit seen;
    clk         = 1'b0;
    resetn      = 1'b0;
    memDout     = nopWord;
    addrCheckEn = 1'b0;
    dataCheckEn = 1'b0;
    expAddr     = '0;
    expData     = '0;
    timeouts    = 0;
    repeat (2) @(posedge clk);
    #1 resetn = 1'b1;
    // extra fetch at the end, only the last write is checked there
    for (int k = 0; k <= numSteps && timeouts == 0; k++) begin
      waitFetch(seen);
      if (!seen) begin
        $display("timeout: no instruction fetch within %0d cycles at step %0d",
                 fetchTimeout, k);
        timeouts++;
      end else begin
        addrCheckEn = (k < numSteps);
        dataCheckEn = (k > 0);
        if (k < numSteps) begin
          expAddr = trace[k].fetchAddr;
        end
        if (k > 0) begin
          expData = trace[k-1].lastWrite; // result of the previous step
        end
        @(posedge clk);
        #1;
        memDout = (k < numSteps) ? trace[k].instr : nopWord; // read in WAIT_INSTR
      end
    end
    $display("summary: %0d address errors, %0d write data errors, %0d fetch period errors, %0d timeouts",
             addrErrors, dataErrors, periodErrors, timeouts);
    if (addrErrors + dataErrors + periodErrors + timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: core_monitor.sv
/* checker for the core trace: at every fetch compares memAddr, lastWriteData
   and the fetch period with the expected values the testbench presents */
module coreMonitor (
  input  logic           clk,
  input  logic           memEn,
  input  rvIsaPkg::wordT memAddr,
  input  rvIsaPkg::wordT lastWriteData,
  input  logic           addrCheckEn,
  input  rvIsaPkg::wordT expAddr,
  input  logic           dataCheckEn,
  input  rvIsaPkg::wordT expData,
  output int             addrErrors,
  output int             dataErrors,
  output int             periodErrors
);
  timeunit 1ns;
  timeprecision 100ps;

  int sinceFetch; // cycles since the last checked fetch, 0 before the first

  initial begin
    addrErrors   = 0;
    dataErrors   = 0;
    periodErrors = 0;
    sinceFetch   = 0;
  end

  // falling edge, mid-cycle where outputs have settled
  always @(negedge clk) begin
    if (memEn && addrCheckEn && memAddr !== expAddr) begin
      $display("CHECK FAILED t=%0t memAddr expected %h actual %h",
               $time, expAddr, memAddr);
      addrErrors++;
    end
    // written at the end of the previous EXECUTE
    if (memEn && dataCheckEn && lastWriteData !== expData) begin
      $display("CHECK FAILED t=%0t lastWriteData expected %h actual %h",
               $time, expData, lastWriteData);
      dataErrors++;
    end
    // one fetch every four cycles once out of reset
    if (memEn && (addrCheckEn || dataCheckEn)) begin
      if (sinceFetch != 0 && sinceFetch != 4) begin
        $display("CHECK FAILED t=%0t memEn period expected 4 actual %0d",
                 $time, sinceFetch);
        periodErrors++;
      end
      sinceFetch = 1;
    end else if (sinceFetch != 0) begin
      sinceFetch++;
    end
  end

endmodule

// File: processor_core.sv
/* multicycle RV32I core, four cycles per instruction
   fetches over a plain read-enable port and shows the last register write */
`include "core_params.svh"

module processorCore (
  input  logic           clk,
  input  logic           resetn,
  input  rvIsaPkg::wordT memDout,
  output rvIsaPkg::wordT memAddr,
  output logic           memEn,
  output rvIsaPkg::wordT lastWriteData
);

  corePkg::cycleStateT state;
  rvIsaPkg::wordT      pc;
  rvIsaPkg::wordT      instrReg;

  // decoder outputs
  logic isAluReg, isBranch, isJalr, isJal;
  logic isAuipc, isLui, isLoad, isStore, isSystem;
  rvIsaPkg::regIdxT rs1Idx, rs2Idx, rdIdx;
  logic [2:0]       funct3;
  logic             subOrArith;
  rvIsaPkg::wordT   immI, immB, immJ, immU;

  rvIsaPkg::wordT    rs1Data, rs2Data;
  rvIsaPkg::wordT    operandB;
  rvIsaPkg::wordT    aluResult, sumResult;
  logic              branchTaken;
  rvIsaPkg::immKindT pcImmKind;
  rvIsaPkg::wordT    pcImm, pcPlusImm, pcPlus4, nextPc;
  rvIsaPkg::wordT    writeData;
  logic              writeEn;

  instrDecoder decodeInst (
    .instrWord(instrReg), .isAluReg(isAluReg), .isAluImm(),
    .isBranch(isBranch), .isJalr(isJalr), .isJal(isJal), .isAuipc(isAuipc),
    .isLui(isLui), .isLoad(isLoad), .isStore(isStore), .isSystem(isSystem),
    .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx), .funct3(funct3),
    .subOrArith(subOrArith), .immI(immI), .immB(immB), .immJ(immJ), .immU(immU)
  );

  regFile regsInst (
    .clk(clk), .resetn(resetn),
    .readEn(state == corePkg::FETCH_REGS), .writeEn(writeEn),
    .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
    .writeData(writeData), .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  // rs2 for register ops and branch compares, immI for the rest
  assign operandB = (isAluReg || isBranch) ? rs2Data : immI;

  alu aluInst (
    .operandA(rs1Data), .operandB(operandB), .funct3(funct3),
    .subOrArith(subOrArith), .isAluReg(isAluReg), .isBranch(isBranch),
    .aluResult(aluResult), .sumResult(sumResult), .branchTaken(branchTaken)
  );

  // pc-relative offset: jal, auipc, else branch
  assign pcImmKind = isJal   ? rvIsaPkg::IMM_J :
                     isAuipc ? rvIsaPkg::IMM_U : rvIsaPkg::IMM_B;

  always_comb begin
    case (pcImmKind)
      rvIsaPkg::IMM_J: pcImm = immJ;
      rvIsaPkg::IMM_U: pcImm = immU;
      default:         pcImm = immB;
    endcase
  end

  assign pcPlusImm = pc + pcImm;
  assign pcPlus4   = pc + rvIsaPkg::wordT'(4);

  assign nextPc = (branchTaken || isJal) ? pcPlusImm :
                  isJalr                 ? {sumResult[`XLEN-1:1], 1'b0} : // target lsb cleared
                                           pcPlus4;

  assign writeData = (isJal || isJalr) ? pcPlus4 :   // link address
                     isLui             ? immU :
                     isAuipc           ? pcPlusImm :
                                         aluResult;

  // loads, stores and system write nothing back
  assign writeEn = (state == corePkg::EXECUTE) && !isBranch && !isStore
                   && !isLoad && !isSystem;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state         <= corePkg::FETCH_INSTR;
      pc            <= `RESET_PC;
      lastWriteData <= '0;
    end else begin
      case (state)
        corePkg::FETCH_INSTR: state <= corePkg::WAIT_INSTR;
        corePkg::WAIT_INSTR:  state <= corePkg::FETCH_REGS;
        corePkg::FETCH_REGS:  state <= corePkg::EXECUTE;
        default: begin // execute
          pc    <= nextPc;
          state <= corePkg::FETCH_INSTR;
        end
      endcase
      if (writeEn && rdIdx != '0) begin
        lastWriteData <= writeData; // debug view of the write
      end
    end
  end

  // memory answers one cycle after memEn
  always_ff @(posedge clk) begin
    if (state == corePkg::WAIT_INSTR) begin
      instrReg <= memDout;
    end
  end

  assign memAddr = pc;
  assign memEn   = (state == corePkg::FETCH_INSTR);

endmodule

// File: reg_file.sv
/* 32 x 32 register file, one write port and two registered read ports
   cleared by reset, x0 reads as zero and ignores writes */
`include "core_params.svh"

module regFile (
  input  logic             clk,
  input  logic             resetn,
  input  logic             readEn,
  input  logic             writeEn,
  input  rvIsaPkg::regIdxT rs1Idx,
  input  rvIsaPkg::regIdxT rs2Idx,
  input  rvIsaPkg::regIdxT rdIdx,
  input  rvIsaPkg::wordT   writeData,
  output rvIsaPkg::wordT   rs1Data,
  output rvIsaPkg::wordT   rs2Data
);

  rvIsaPkg::wordT regs [`REG_COUNT];

  // write at the clock edge, x0 stays at its reset value
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && rdIdx != '0) begin
      regs[rdIdx] <= writeData;
    end
  end

  // read ports, data valid the cycle after readEn
  always_ff @(posedge clk) begin
    if (readEn) begin
      rs1Data <= regs[rs1Idx];
      rs2Data <= regs[rs2Idx];
    end
  end

endmodule

// File: alu.sv
/* RV32I ALU: add/sub, one shifter for both directions, compares and logic
   also evaluates the branch condition from the same subtraction */
`include "core_params.svh"

module alu (
  input  rvIsaPkg::wordT operandA,
  input  rvIsaPkg::wordT operandB,
  input  logic [2:0]     funct3,
  input  logic           subOrArith,
  input  logic           isAluReg,
  input  logic           isBranch,
  output rvIsaPkg::wordT aluResult,
  output rvIsaPkg::wordT sumResult,
  output logic           branchTaken
);

  logic [`XLEN:0]   diffWide;   // a - b with borrow in the top bit
  corePkg::cmpFlagsT cmp;
  logic [4:0]       shamt;
  rvIsaPkg::wordT   shiftIn;
  logic [`XLEN:0]   shiftWide;  // sign bit prepended for sra
  rvIsaPkg::wordT   shiftRight;
  rvIsaPkg::wordT   shiftLeft;
  logic             condMet;

  // reverse bit order, lets the right shifter do left shifts too
  function automatic rvIsaPkg::wordT flipWord(input rvIsaPkg::wordT x);
    rvIsaPkg::wordT y;
    for (int i = 0; i < `XLEN; i++) begin
      y[i] = x[`XLEN-1-i];
    end
    return y;
  endfunction

  assign sumResult = operandA + operandB; // also jalr target, addi
  assign diffWide  = {1'b0, operandA} - {1'b0, operandB};

  assign cmp.eq  = (diffWide[`XLEN-1:0] == '0);
  assign cmp.ltu = diffWide[`XLEN]; // borrow out
  // signs differ: a negative means a < b; otherwise borrow decides
  assign cmp.lt  = (operandA[`XLEN-1] ^ operandB[`XLEN-1]) ? operandA[`XLEN-1]
                                                           : diffWide[`XLEN];

  assign shamt      = operandB[4:0]; // rs2 or the shamt field of immI
  assign shiftIn    = (funct3 == rvIsaPkg::F3_SLL) ? flipWord(operandA) : operandA;
  assign shiftWide  = $signed({subOrArith & operandA[`XLEN-1], shiftIn}) >>> shamt;
  assign shiftRight = shiftWide[`XLEN-1:0];
  assign shiftLeft  = flipWord(shiftRight);

  always_comb begin
    case (rvIsaPkg::aluFunct3T'(funct3))
      rvIsaPkg::F3_ADD:  aluResult = (subOrArith && isAluReg) ? diffWide[`XLEN-1:0]
                                                             : sumResult; // addi never subtracts
      rvIsaPkg::F3_SLL:  aluResult = shiftLeft;
      rvIsaPkg::F3_SLT:  aluResult = {{(`XLEN-1){1'b0}}, cmp.lt};
      rvIsaPkg::F3_SLTU: aluResult = {{(`XLEN-1){1'b0}}, cmp.ltu};
      rvIsaPkg::F3_XOR:  aluResult = operandA ^ operandB;
      rvIsaPkg::F3_SR:   aluResult = shiftRight; // srl or sra
      rvIsaPkg::F3_OR:   aluResult = operandA | operandB;
      default:           aluResult = operandA & operandB; // and
    endcase
  end

  always_comb begin
    case (rvIsaPkg::branchFunct3T'(funct3))
      rvIsaPkg::BR_EQ:  condMet = cmp.eq;
      rvIsaPkg::BR_NE:  condMet = ~cmp.eq;
      rvIsaPkg::BR_LT:  condMet = cmp.lt;
      rvIsaPkg::BR_GE:  condMet = ~cmp.lt;
      rvIsaPkg::BR_LTU: condMet = cmp.ltu;
      rvIsaPkg::BR_GEU: condMet = ~cmp.ltu;
      default:          condMet = 1'b0; // reserved funct3
    endcase
  end

  assign branchTaken = isBranch & condMet;

endmodule

// File: instr_decoder.sv
/* combinational decode of the latched instruction word
   gives class flags, register fields, funct bits and sign-extended immediates */
module instrDecoder (
  input  rvIsaPkg::wordT   instrWord,
  output logic             isAluReg,
  output logic             isAluImm,
  output logic             isBranch,
  output logic             isJalr,
  output logic             isJal,
  output logic             isAuipc,
  output logic             isLui,
  output logic             isLoad,
  output logic             isStore,
  output logic             isSystem,
  output rvIsaPkg::regIdxT rs1Idx,
  output rvIsaPkg::regIdxT rs2Idx,
  output rvIsaPkg::regIdxT rdIdx,
  output logic [2:0]       funct3,
  output logic             subOrArith,
  output rvIsaPkg::wordT   immI,
  output rvIsaPkg::wordT   immB,
  output rvIsaPkg::wordT   immJ,
  output rvIsaPkg::wordT   immU
);

  rvIsaPkg::opcodeT opcode;

  assign opcode = rvIsaPkg::opcodeT'(instrWord[6:0]);

  // one flag per instruction class
  assign isAluReg = (opcode == rvIsaPkg::ALUREG);
  assign isAluImm = (opcode == rvIsaPkg::ALUIMM);
  assign isBranch = (opcode == rvIsaPkg::BRANCH);
  assign isJalr   = (opcode == rvIsaPkg::JALR);
  assign isJal    = (opcode == rvIsaPkg::JAL);
  assign isAuipc  = (opcode == rvIsaPkg::AUIPC);
  assign isLui    = (opcode == rvIsaPkg::LUI);
  assign isLoad   = (opcode == rvIsaPkg::LOAD);
  assign isStore  = (opcode == rvIsaPkg::STORE);
  assign isSystem = (opcode == rvIsaPkg::SYSTEM);

  // register fields sit at fixed positions in every format
  assign rs1Idx = instrWord[19:15];
  assign rs2Idx = instrWord[24:20]; // also shamt for immediate shifts
  assign rdIdx  = instrWord[11:7];

  assign funct3     = instrWord[14:12];
  assign subOrArith = instrWord[30]; // funct7[5]: sub, sra, srai

  // I: 12-bit signed
  assign immI = {{21{instrWord[31]}}, instrWord[30:20]};

  // B: even offset, +-4 KiB
  assign immB = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                 instrWord[11:8], 1'b0};

  // J: even offset, +-1 MiB
  assign immJ = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                 instrWord[30:21], 1'b0};

  // U: upper 20 bits, low 12 zero
  assign immU = {instrWord[31:12], 12'b0};

endmodule

// File: core_pkg.sv
/* types private to the core: cycle state and the compare flags
   produced by the ALU subtractor */
package corePkg;

  // one instruction walks through all four states
  typedef enum logic [1:0] {
    FETCH_INSTR = 2'd0, // memEn high, address = pc
    WAIT_INSTR  = 2'd1, // memDout valid, latched at the end
    FETCH_REGS  = 2'd2, // register file read
    EXECUTE     = 2'd3  // alu, write-back, pc update
  } cycleStateT;

  // compare results from the single 33-bit subtraction
  typedef struct packed {
    logic eq;  // a == b
    logic lt;  // signed a < b
    logic ltu; // unsigned a < b
  } cmpFlagsT;

endpackage

// File: rv_isa_pkg.sv
/* RISC-V RV32I encoding types shared by the decoder, the ALU and the core
   opcodes, funct3 codes, word and index types */
`include "core_params.svh"

package rvIsaPkg;

  typedef logic [`XLEN-1:0] wordT;       // data and address word
  typedef logic [`REG_IDX_W-1:0] regIdxT; // x0..x31

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    ALUREG = 7'b0110011, // rd <- rs1 op rs2
    ALUIMM = 7'b0010011, // rd <- rs1 op immI
    BRANCH = 7'b1100011, // pc <- pc + immB when taken
    JALR   = 7'b1100111, // rd <- pc + 4, pc <- rs1 + immI
    JAL    = 7'b1101111, // rd <- pc + 4, pc <- pc + immJ
    AUIPC  = 7'b0010111, // rd <- pc + immU
    LUI    = 7'b0110111, // rd <- immU
    LOAD   = 7'b0000011, // no data memory here
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011  // ecall / ebreak, treated as nop
  } opcodeT;

  // ALU function codes
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000, // add / sub
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101, // srl / sra by instr[30]
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } aluFunct3T;

  // branch conditions, 010 and 011 unused
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branchFunct3T;

  // immediate formats kept by this core, S-type gone with stores
  typedef enum logic [1:0] {
    IMM_I,
    IMM_B,
    IMM_J,
    IMM_U
  } immKindT;

endpackage

// File: core_params.svh
/* core-wide sizes and reset values for the RV32I multicycle core
   include wherever a width or the reset PC is needed */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// bits of a register index
`define REG_IDX_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
